/* source/fdtd_pkg.sv */
package fdtd_pkg;

    //////////////////////////////
    // bus and field widths
    //////////////////////////////

    // byte address on the bus
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    // word address, byte offset dropped
    localparam int WORD_ADDR_W = ADDR_W - 2;

    // word count given at start
    localparam int SIZE_W      = 16;

    //////////////////////////////
    // block geometry
    //////////////////////////////

    // words per field in one block, power of two
    localparam int BUF_WORDS   = 8;
    localparam int BUF_CNT_W   = $clog2(BUF_WORDS);
    // enough for size / BUF_WORDS
    localparam int BLK_CNT_W   = SIZE_W - BUF_CNT_W;

    // field of the current transfer
    typedef enum logic
    {
        FIELD_HY = 1'b0,
        FIELD_EZ = 1'b1
    } field_e;

endpackage

/* source/mem_req_if.sv */
interface mem_req_if;

    // one word request, one item in flight
    logic                               req;
    logic                               we;
    logic [fdtd_pkg::WORD_ADDR_W-1:0]   word_addr;
    logic [fdtd_pkg::DATA_W-1:0]        wdata;
    logic [fdtd_pkg::DATA_W-1:0]        rdata;
    // single cycle, rdata valid with it
    logic                               gnt;

    modport seq
    (
        output req,
        output we,
        input  gnt
    );

    modport addr
    (
        output word_addr,
        input  gnt,
        input  we
    );

    modport master
    (
        input  req,
        input  we,
        input  word_addr,
        input  wdata,
        output rdata,
        output gnt
    );

    modport mon
    (
        input  gnt
    );

endinterface

/* source/fdtd_seq_fsm.sv */
module fdtd_seq_fsm
(
    input  logic                ACLK,
    input  logic                ARESETn,

    input  logic                start_i,
    input  logic                calc_done_i,
    input  logic                int_en_i,
    input  logic                int_clr_i,
    input  logic                buf_done_i,
    input  logic                last_block_i,

    mem_req_if.seq              mem,

    output logic                load_o,
    output logic                block_done_o,
    output logic                busy_o,
    output logic                buf_ready_o,
    output logic                rd_valid_o,
    output logic                wr_take_o,
    output logic                int_pending_o,
    output logic                int_o,
    output fdtd_pkg::field_e    field_o
);
    import fdtd_pkg::*;

    typedef enum logic [2:0]
    {
        IDLE,
        READ_HY,
        READ_EZ,
        CALC_WAIT,
        WRITE_HY,
        WRITE_EZ
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   busy_q;
    logic   busy_prev_q;
    logic   int_pending_q;

    //////////////////////////////
    // phase sequencing
    //////////////////////////////

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d      = state_q;
        load_o       = 1'b0;
        block_done_o = 1'b0;
        case (state_q)
            IDLE:
            begin
                if (start_i)
                begin
                    load_o  = 1'b1;
                    state_d = READ_HY;
                end
            end
            READ_HY:
            begin
                if (buf_done_i)
                    state_d = READ_EZ;
            end
            READ_EZ:
            begin
                if (buf_done_i)
                    state_d = CALC_WAIT;
            end
            // block loaded, compute side owns it now
            CALC_WAIT:
            begin
                if (calc_done_i)
                    state_d = WRITE_HY;
            end
            WRITE_HY:
            begin
                if (buf_done_i)
                    state_d = WRITE_EZ;
            end
            WRITE_EZ:
            begin
                if (buf_done_i)
                begin
                    block_done_o = 1'b1;
                    state_d      = last_block_i ? IDLE : READ_HY;
                end
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    // word requests while in a transfer phase
    assign mem.req = (state_q == READ_HY) || (state_q == READ_EZ) ||
                     (state_q == WRITE_HY) || (state_q == WRITE_EZ);
    assign mem.we  = (state_q == WRITE_HY) || (state_q == WRITE_EZ);

    assign rd_valid_o  = mem.gnt && ((state_q == READ_HY) || (state_q == READ_EZ));
    assign wr_take_o   = mem.gnt && mem.we;
    assign buf_ready_o = (state_q == CALC_WAIT);
    assign field_o     = ((state_q == READ_EZ) || (state_q == WRITE_EZ)) ? FIELD_EZ : FIELD_HY;

    //////////////////////////////
    // status and interrupt
    //////////////////////////////

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            busy_q      <= 1'b0;
            busy_prev_q <= 1'b0;
        end
        else
        begin
            busy_q      <= (state_d != IDLE);
            busy_prev_q <= busy_q;
        end
    end

    // sticky until cleared, clear wins over a new falling edge
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            int_pending_q <= 1'b0;
        else if (int_clr_i)
            int_pending_q <= 1'b0;
        else if (busy_prev_q && !busy_q)
            int_pending_q <= 1'b1;
    end

    assign busy_o        = busy_q;
    assign int_pending_o = int_pending_q;
    assign int_o         = int_en_i & int_pending_q;

endmodule

/* source/fdtd_word_counter.sv */
module fdtd_word_counter
(
    input  logic                        ACLK,
    input  logic                        ARESETn,

    input  logic                        load_i,
    input  logic                        block_done_i,
    input  logic [fdtd_pkg::SIZE_W-1:0] size_i,

    mem_req_if.mon                      mem,

    output logic                        buf_done_o,
    output logic                        last_block_o
);
    import fdtd_pkg::*;

    logic [BUF_CNT_W-1:0] word_cnt_q;
    logic [BLK_CNT_W-1:0] blk_cnt_q;
    logic                 word_last;

    assign word_last = (word_cnt_q == BUF_CNT_W'(BUF_WORDS - 1));

    // words done within the current field block
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            word_cnt_q <= '0;
        else if (load_i)
            word_cnt_q <= '0;
        else if (mem.gnt)
        begin
            if (word_last)
                word_cnt_q <= '0;
            else
                word_cnt_q <= word_cnt_q + 1'b1;
        end
    end

    // blocks still to process
    // size is a whole number of blocks, so the low bits are dropped
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            blk_cnt_q <= '0;
        else if (load_i)
            blk_cnt_q <= size_i[SIZE_W-1:BUF_CNT_W];
        else if (block_done_i)
            blk_cnt_q <= blk_cnt_q - 1'b1;
    end

    assign buf_done_o   = mem.gnt && word_last;
    assign last_block_o = (blk_cnt_q == BLK_CNT_W'(1));

endmodule

/* source/fdtd_addr_gen.sv */
module fdtd_addr_gen
(
    input  logic                        ACLK,
    input  logic                        ARESETn,

    input  logic                        load_i,
    input  logic [fdtd_pkg::ADDR_W-1:0] hy_base_i,
    input  logic [fdtd_pkg::ADDR_W-1:0] ez_base_i,
    input  fdtd_pkg::field_e            field_i,

    mem_req_if.addr                     mem
);
    import fdtd_pkg::*;

    // pointer slots, indexed by {we, field}
    localparam logic [1:0] RD_HY = {1'b0, FIELD_HY};
    localparam logic [1:0] RD_EZ = {1'b0, FIELD_EZ};
    localparam logic [1:0] WR_HY = {1'b1, FIELD_HY};
    localparam logic [1:0] WR_EZ = {1'b1, FIELD_EZ};

    logic [WORD_ADDR_W-1:0] ptr_q [4];
    logic [1:0]             sel;

    assign sel = {mem.we, field_i};

    //////////////////////////////
    // word pointers
    //////////////////////////////

    // read and write of one field start at the same base,
    // write side trails the read side by one block
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            ptr_q[RD_HY] <= '0;
            ptr_q[RD_EZ] <= '0;
            ptr_q[WR_HY] <= '0;
            ptr_q[WR_EZ] <= '0;
        end
        else if (load_i)
        begin
            ptr_q[RD_HY] <= hy_base_i[ADDR_W-1:2];
            ptr_q[RD_EZ] <= ez_base_i[ADDR_W-1:2];
            ptr_q[WR_HY] <= hy_base_i[ADDR_W-1:2];
            ptr_q[WR_EZ] <= ez_base_i[ADDR_W-1:2];
        end
        else if (mem.gnt)
        begin
            // field and we are stable through the gnt cycle
            ptr_q[sel] <= ptr_q[sel] + 1'b1;
        end
    end

    assign mem.word_addr = ptr_q[sel];

endmodule

/* source/fdtd_wb_master.sv */
module fdtd_wb_master
(
    input  logic                        ACLK,
    input  logic                        ARESETn,

    mem_req_if.master                   mem,

    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [fdtd_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [fdtd_pkg::DATA_W-1:0] wb_dat_o,
    input  logic [fdtd_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                        wb_ack_i
);
    import fdtd_pkg::*;

    typedef enum logic [1:0]
    {
        M_IDLE,
        M_BUS,
        M_GNT
    } mstate_e;

    mstate_e                state_q;
    logic                   we_q;
    logic [WORD_ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0]      wdata_q;
    logic [DATA_W-1:0]      rdata_q;

    // accept only when idle, never in the gnt cycle
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q <= M_IDLE;
            we_q    <= 1'b0;
        end
        else
        begin
            case (state_q)
                M_IDLE:
                begin
                    if (mem.req)
                    begin
                        state_q <= M_BUS;
                        we_q    <= mem.we;
                    end
                end
                // hold strobes until the slave acks, wait states allowed
                M_BUS:
                begin
                    if (wb_ack_i)
                        state_q <= M_GNT;
                end
                M_GNT:
                begin
                    state_q <= M_IDLE;
                end
                default:
                begin
                    state_q <= M_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ACLK)
    begin
        if ((state_q == M_IDLE) && mem.req)
        begin
            addr_q  <= mem.word_addr;
            wdata_q <= mem.wdata;
        end
        if ((state_q == M_BUS) && wb_ack_i)
            rdata_q <= wb_dat_i;
    end

    assign wb_cyc_o = (state_q == M_BUS);
    assign wb_stb_o = (state_q == M_BUS);
    assign wb_we_o  = (state_q == M_BUS) && we_q;
    assign wb_adr_o = {addr_q, 2'b00};
    assign wb_dat_o = wdata_q;

    assign mem.gnt   = (state_q == M_GNT);
    assign mem.rdata = rdata_q;

endmodule

/* source/fdtd_mem_ctrl.sv */
module fdtd_mem_ctrl
(
    input  logic                        ACLK,
    input  logic                        ARESETn,

    // control
    input  logic                        start_i,
    input  logic [fdtd_pkg::ADDR_W-1:0] hy_base_i,
    input  logic [fdtd_pkg::ADDR_W-1:0] ez_base_i,
    input  logic [fdtd_pkg::SIZE_W-1:0] size_i,
    input  logic                        int_en_i,
    input  logic                        int_clr_i,

    // status
    output logic                        busy_o,
    output logic                        int_pending_o,
    output logic                        int_o,

    // compute side
    output logic                        rd_valid_o,
    output fdtd_pkg::field_e            rd_field_o,
    output logic [fdtd_pkg::DATA_W-1:0] rd_data_o,
    output logic                        buf_ready_o,
    input  logic                        calc_done_i,
    output logic                        wr_take_o,
    output fdtd_pkg::field_e            wr_field_o,
    input  logic [fdtd_pkg::DATA_W-1:0] wr_data_i,

    // wishbone classic master
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [fdtd_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [fdtd_pkg::DATA_W-1:0] wb_dat_o,
    input  logic [fdtd_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                        wb_ack_i
);
    import fdtd_pkg::*;

    field_e field;
    logic   load;
    logic   block_done;
    logic   buf_done;
    logic   last_block;

    mem_req_if mem ();

    // compute side data goes straight through the request channel
    assign mem.wdata  = wr_data_i;
    assign rd_data_o  = mem.rdata;
    assign rd_field_o = field;
    assign wr_field_o = field;

    fdtd_seq_fsm i_seq_fsm
    (
        .ACLK           ( ACLK          ),
        .ARESETn        ( ARESETn       ),
        .start_i        ( start_i       ),
        .calc_done_i    ( calc_done_i   ),
        .int_en_i       ( int_en_i      ),
        .int_clr_i      ( int_clr_i     ),
        .buf_done_i     ( buf_done      ),
        .last_block_i   ( last_block    ),
        .mem            ( mem.seq       ),
        .load_o         ( load          ),
        .block_done_o   ( block_done    ),
        .busy_o         ( busy_o        ),
        .buf_ready_o    ( buf_ready_o   ),
        .rd_valid_o     ( rd_valid_o    ),
        .wr_take_o      ( wr_take_o     ),
        .int_pending_o  ( int_pending_o ),
        .int_o          ( int_o         ),
        .field_o        ( field         )
    );

    fdtd_word_counter i_word_counter
    (
        .ACLK           ( ACLK          ),
        .ARESETn        ( ARESETn       ),
        .load_i         ( load          ),
        .block_done_i   ( block_done    ),
        .size_i         ( size_i        ),
        .mem            ( mem.mon       ),
        .buf_done_o     ( buf_done      ),
        .last_block_o   ( last_block    )
    );

    fdtd_addr_gen i_addr_gen
    (
        .ACLK           ( ACLK          ),
        .ARESETn        ( ARESETn       ),
        .load_i         ( load          ),
        .hy_base_i      ( hy_base_i     ),
        .ez_base_i      ( ez_base_i     ),
        .field_i        ( field         ),
        .mem            ( mem.addr      )
    );

    fdtd_wb_master i_wb_master
    (
        .ACLK           ( ACLK          ),
        .ARESETn        ( ARESETn       ),
        .mem            ( mem.master    ),
        .wb_cyc_o       ( wb_cyc_o      ),
        .wb_stb_o       ( wb_stb_o      ),
        .wb_we_o        ( wb_we_o       ),
        .wb_adr_o       ( wb_adr_o      ),
        .wb_dat_o       ( wb_dat_o      ),
        .wb_dat_i       ( wb_dat_i      ),
        .wb_ack_i       ( wb_ack_i      )
    );

endmodule

/* test/wb_mem_model.sv */
module wb_mem_model
#(
    parameter int DEPTH = 256
)
(
    input  logic                        ACLK,
    input  logic                        ARESETn,

    // random wait states on or off
    input  logic                        rand_wait_i,

    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [fdtd_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [fdtd_pkg::DATA_W-1:0] wb_dat_i,
    output logic [fdtd_pkg::DATA_W-1:0] wb_dat_o,
    output logic                        wb_ack_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import fdtd_pkg::*;

    localparam int          AW        = $clog2(DEPTH);
    localparam logic [31:0] LFSR_SEED = 32'hfa04;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic [DATA_W-1:0] mem [DEPTH];

    logic [31:0]       lfsr_q;
    logic [31:0]       lfsr_a;
    logic [31:0]       lfsr_b;
    logic [1:0]        wait_draw;
    logic [1:0]        wait_q;
    logic              armed_q;
    logic              ack_q;
    logic [AW-1:0]     word;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    assign word = wb_adr_i[AW+1:2];

    // two bits per ack, one step per bit
    assign lfsr_a    = lfsr_step(lfsr_q);
    assign lfsr_b    = lfsr_step(lfsr_a);
    assign wait_draw = rand_wait_i ? {lfsr_q[0], lfsr_a[0]} : 2'b00;

    //////////////////////////////
    // ack with wait states
    //////////////////////////////

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            lfsr_q  <= LFSR_SEED;
            wait_q  <= '0;
            armed_q <= 1'b0;
            ack_q   <= 1'b0;
        end
        else
        begin
            ack_q <= 1'b0;
            if (wb_cyc_i && wb_stb_i && !ack_q)
            begin
                if (!armed_q)
                begin
                    // new bus cycle, draw its wait states
                    if (rand_wait_i)
                        lfsr_q <= lfsr_b;
                    if (wait_draw == 2'd0)
                        ack_q <= 1'b1;
                    else
                    begin
                        armed_q <= 1'b1;
                        wait_q  <= wait_draw - 2'd1;
                    end
                end
                else if (wait_q == 2'd0)
                begin
                    armed_q <= 1'b0;
                    ack_q   <= 1'b1;
                end
                else
                    wait_q <= wait_q - 2'd1;
            end
        end
    end

    // write lands in the ack cycle
    always @(posedge ACLK)
    begin
        if (wb_cyc_i && wb_stb_i && wb_we_i && ack_q)
            mem[word] <= wb_dat_i;
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = ack_q ? mem[word] : '0;

endmodule

/* test/tb_fdtd_mem_ctrl.sv */
module tb_fdtd_mem_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    import fdtd_pkg::*;

    localparam int MEM_DEPTH      = 256;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int CALC_DELAY     = 3;
    localparam int BLK_WORDS      = 2 * BUF_WORDS;

    logic              ACLK = 1'b0;
    logic              ARESETn;
    logic              start_i;
    logic [ADDR_W-1:0] hy_base_i;
    logic [ADDR_W-1:0] ez_base_i;
    logic [SIZE_W-1:0] size_i;
    logic              int_en_i;
    logic              int_clr_i;
    logic              busy_o;
    logic              int_pending_o;
    logic              int_o;
    logic              rd_valid_o;
    field_e            rd_field_o;
    logic [DATA_W-1:0] rd_data_o;
    logic              buf_ready_o;
    logic              calc_done_i = 1'b0;
    logic              wr_take_o;
    field_e            wr_field_o;
    logic [DATA_W-1:0] wr_data_i = '0;
    logic              wb_cyc_o;
    logic              wb_stb_o;
    logic              wb_we_o;
    logic [ADDR_W-1:0] wb_adr_o;
    logic [DATA_W-1:0] wb_dat_o;
    logic [DATA_W-1:0] wb_dat_i;
    logic              wb_ack_i;
    logic              rand_wait;

    // expected memory contents
    logic [DATA_W-1:0] shadow [MEM_DEPTH];
    // words of the current block, Hy then Ez
    logic [DATA_W-1:0] rd_buf [BLK_WORDS];

    int                err_cnt     = 0;
    int                timeout_cnt = 0;
    int                run_hy_w;
    int                run_ez_w;
    int                rd_hy_n;
    int                rd_ez_n;
    int                wr_hy_n;
    int                wr_ez_n;
    int                rd_n;
    int                wr_n;
    int                rd_blk_cnt;
    int                wr_blk_cnt;
    int                ready_rises;
    int                calc_cnt;
    int                calc_wait;
    int                exp_word;
    logic              ready_prev;
    logic              wr_phase;
    field_e            model_field;
    logic [DATA_W-1:0] model_word;

    always #10 ACLK = ~ACLK;

    fdtd_mem_ctrl i_dut
    (
        .ACLK           ( ACLK          ),
        .ARESETn        ( ARESETn       ),
        .start_i        ( start_i       ),
        .hy_base_i      ( hy_base_i     ),
        .ez_base_i      ( ez_base_i     ),
        .size_i         ( size_i        ),
        .int_en_i       ( int_en_i      ),
        .int_clr_i      ( int_clr_i     ),
        .busy_o         ( busy_o        ),
        .int_pending_o  ( int_pending_o ),
        .int_o          ( int_o         ),
        .rd_valid_o     ( rd_valid_o    ),
        .rd_field_o     ( rd_field_o    ),
        .rd_data_o      ( rd_data_o     ),
        .buf_ready_o    ( buf_ready_o   ),
        .calc_done_i    ( calc_done_i   ),
        .wr_take_o      ( wr_take_o     ),
        .wr_field_o     ( wr_field_o    ),
        .wr_data_i      ( wr_data_i     ),
        .wb_cyc_o       ( wb_cyc_o      ),
        .wb_stb_o       ( wb_stb_o      ),
        .wb_we_o        ( wb_we_o       ),
        .wb_adr_o       ( wb_adr_o      ),
        .wb_dat_o       ( wb_dat_o      ),
        .wb_dat_i       ( wb_dat_i      ),
        .wb_ack_i       ( wb_ack_i      )
    );

    wb_mem_model #(.DEPTH(MEM_DEPTH)) i_mem
    (
        .ACLK           ( ACLK          ),
        .ARESETn        ( ARESETn       ),
        .rand_wait_i    ( rand_wait     ),
        .wb_cyc_i       ( wb_cyc_o      ),
        .wb_stb_i       ( wb_stb_o      ),
        .wb_we_i        ( wb_we_o       ),
        .wb_adr_i       ( wb_adr_o      ),
        .wb_dat_i       ( wb_dat_o      ),
        .wb_dat_o       ( wb_dat_i      ),
        .wb_ack_o       ( wb_ack_i      )
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [DATA_W-1:0] ref_update(input field_e field,
                                                     input logic [DATA_W-1:0] old);
        if (field == FIELD_HY)
            return old + 1'b1;
        return old ^ 32'hffff_0000;
    endfunction

    // initial contents, spread over the whole word address
    function automatic logic [DATA_W-1:0] fill_word(input int unsigned word);
        logic [31:0] w;
        w = word;
        return (w * 32'h9e37_79b1) ^ {w[15:0], ~w[15:0]};
    endfunction

    function automatic logic [DATA_W-1:0] new_value(input int idx);
        if (idx < BUF_WORDS)
            return ref_update(FIELD_HY, rd_buf[idx]);
        return ref_update(FIELD_EZ, rd_buf[idx]);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            err_cnt++;
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while ((busy_o !== level) && (n < TIMEOUT_CYCLES))
        begin
            @(negedge ACLK);
            n++;
        end
        if (busy_o !== level)
        begin
            $display("timeout: busy_o did not go to %0b within %0d cycles", level,
                     TIMEOUT_CYCLES);
            timeout_cnt++;
        end
    endtask

    task automatic check_idle_outputs();
        check_eq("busy_o", busy_o, 1'b0);
        check_eq("int_pending_o", int_pending_o, 1'b0);
        check_eq("int_o", int_o, 1'b0);
        check_eq("buf_ready_o", buf_ready_o, 1'b0);
        check_eq("rd_valid_o", rd_valid_o, 1'b0);
        check_eq("wr_take_o", wr_take_o, 1'b0);
        check_eq("wb_cyc_o", wb_cyc_o, 1'b0);
        check_eq("wb_stb_o", wb_stb_o, 1'b0);
        check_eq("wb_we_o", wb_we_o, 1'b0);
    endtask

    task automatic compare_memory();
        for (int a = 0; a < MEM_DEPTH; a++)
            check_eq($sformatf("mem[0x%03h]", a * 4), i_mem.mem[a], shadow[a]);
    endtask

    // one start, then wait for busy to drop
    task automatic run_fields(input logic [ADDR_W-1:0] hy_base,
                              input logic [ADDR_W-1:0] ez_base,
                              input int words, input logic rand_en);
        run_hy_w = hy_base >> 2;
        run_ez_w = ez_base >> 2;
        for (int k = 0; k < words; k++)
        begin
            shadow[run_hy_w + k] = ref_update(FIELD_HY, shadow[run_hy_w + k]);
            shadow[run_ez_w + k] = ref_update(FIELD_EZ, shadow[run_ez_w + k]);
        end
        rd_hy_n     = 0;
        rd_ez_n     = 0;
        wr_hy_n     = 0;
        wr_ez_n     = 0;
        rd_n        = 0;
        wr_n        = 0;
        rd_blk_cnt  = 0;
        ready_rises = 0;
        calc_cnt    = 0;
        @(negedge ACLK);
        hy_base_i = hy_base;
        ez_base_i = ez_base;
        size_i    = words;
        rand_wait = rand_en;
        start_i   = 1'b1;
        @(negedge ACLK);
        start_i = 1'b0;
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_eq("rd_valid_o count", rd_n, 2 * words);
        check_eq("wr_take_o count", wr_n, 2 * words);
        check_eq("buf_ready_o rises", ready_rises, words / BUF_WORDS);
        check_eq("calc_done_i count", calc_cnt, words / BUF_WORDS);
        compare_memory();
    endtask

    //////////////////////////////
    // compute side model
    //////////////////////////////

    always @(negedge ACLK)
    begin
        calc_done_i = 1'b0;
        if (ARESETn)
        begin
            if (buf_ready_o && !ready_prev)
                ready_rises++;
            ready_prev = buf_ready_o;
            // word in flight on the bus
            if (wb_cyc_o)
            begin
                check_eq("wb_we_o", wb_we_o, wr_phase);
                if (wr_phase)
                begin
                    exp_word = (wr_blk_cnt < BUF_WORDS) ? run_hy_w + wr_hy_n
                                                        : run_ez_w + wr_ez_n;
                    check_eq("wb_dat_o", wb_dat_o, new_value(wr_blk_cnt));
                end
                else
                    exp_word = (rd_blk_cnt < BUF_WORDS) ? run_hy_w + rd_hy_n
                                                        : run_ez_w + rd_ez_n;
                check_eq("wb_adr_o", wb_adr_o, 4 * exp_word);
            end
            if (rd_valid_o)
            begin
                model_field = (rd_blk_cnt < BUF_WORDS) ? FIELD_HY : FIELD_EZ;
                check_eq("rd_field_o", rd_field_o, model_field);
                if (model_field == FIELD_HY)
                begin
                    model_word = fill_word(run_hy_w + rd_hy_n);
                    rd_hy_n++;
                end
                else
                begin
                    model_word = fill_word(run_ez_w + rd_ez_n);
                    rd_ez_n++;
                end
                check_eq("rd_data_o", rd_data_o, model_word);
                if (rd_blk_cnt < BLK_WORDS)
                    rd_buf[rd_blk_cnt] = rd_data_o;
                rd_blk_cnt++;
                rd_n++;
            end
            if (wr_take_o)
            begin
                model_field = (wr_blk_cnt < BUF_WORDS) ? FIELD_HY : FIELD_EZ;
                check_eq("wr_field_o", wr_field_o, model_field);
                if (model_field == FIELD_HY)
                    wr_hy_n++;
                else
                    wr_ez_n++;
                wr_blk_cnt++;
                wr_n++;
                // next value from this falling edge on
                if (wr_blk_cnt < BLK_WORDS)
                    wr_data_i = new_value(wr_blk_cnt);
                else
                    wr_phase = 1'b0;
            end
            if (buf_ready_o)
            begin
                calc_wait++;
                if (calc_wait == CALC_DELAY)
                begin
                    calc_done_i = 1'b1;
                    calc_wait   = 0;
                    calc_cnt++;
                    rd_blk_cnt  = 0;
                    wr_blk_cnt  = 0;
                    wr_phase    = 1'b1;
                    wr_data_i   = new_value(0);
                end
            end
        end
        else
        begin
            ready_prev = 1'b0;
            calc_wait  = 0;
            wr_phase   = 1'b0;
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        ARESETn   = 1'b0;
        start_i   = 1'b0;
        hy_base_i = '0;
        ez_base_i = '0;
        size_i    = '0;
        int_en_i  = 1'b0;
        int_clr_i = 1'b0;
        rand_wait = 1'b0;
        for (int a = 0; a < MEM_DEPTH; a++)
        begin
            i_mem.mem[a] = fill_word(a);
            shadow[a]    = fill_word(a);
        end
        repeat (8) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        @(negedge ACLK);
        check_idle_outputs();

        // single block, no wait states
        run_fields(32'h0000_0040, 32'h0000_0100, BUF_WORDS, 1'b0);
        check_eq("int_pending_o", int_pending_o, 1'b0);
        @(negedge ACLK);
        check_eq("int_pending_o", int_pending_o, 1'b1);
        repeat (3) @(negedge ACLK);
        check_eq("int_pending_o", int_pending_o, 1'b1);
        check_eq("int_o", int_o, 1'b0);
        int_en_i = 1'b1;
        @(negedge ACLK);
        check_eq("int_o", int_o, 1'b1);
        int_clr_i = 1'b1;
        @(negedge ACLK);
        int_clr_i = 1'b0;
        check_eq("int_pending_o", int_pending_o, 1'b0);
        check_eq("int_o", int_o, 1'b0);

        // three blocks with random wait states
        run_fields(32'h0000_0200, 32'h0000_0300, 3 * BUF_WORDS, 1'b1);
        @(negedge ACLK);
        check_eq("int_pending_o", int_pending_o, 1'b1);
        check_eq("int_o", int_o, 1'b1);
        int_clr_i = 1'b1;
        @(negedge ACLK);
        int_clr_i = 1'b0;
        check_eq("int_pending_o", int_pending_o, 1'b0);

        $display("run complete, %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if ((err_cnt == 0) && (timeout_cnt == 0))
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* src.f */
source/fdtd_pkg.sv
source/mem_req_if.sv
source/fdtd_seq_fsm.sv
source/fdtd_word_counter.sv
source/fdtd_addr_gen.sv
source/fdtd_wb_master.sv
source/fdtd_mem_ctrl.sv
test/wb_mem_model.sv
test/tb_fdtd_mem_ctrl.sv

/* Bender.yml */
package:
  name: fdtd_mem_ctrl

sources:
  - source/fdtd_pkg.sv
  - source/mem_req_if.sv
  - source/fdtd_seq_fsm.sv
  - source/fdtd_word_counter.sv
  - source/fdtd_addr_gen.sv
  - source/fdtd_wb_master.sv
  - source/fdtd_mem_ctrl.sv
  - target: test
    files:
      - test/wb_mem_model.sv
      - test/tb_fdtd_mem_ctrl.sv
